//--- common/mfPkg.sv
// widths, bus constants, sample/coeff/result structs, register map
package mfPkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int SAMPLE_W = 12;   // I/Q sample
   localparam int COEFF_W  = 16;   // one coefficient part
   localparam int RESULT_W = 32;   // one filter output, no truncation
   localparam int NUM_TAPS = 4;    // taps per symbol
   localparam int ADDR_W   = 8;    // apb address
   localparam int DATA_W   = 32;   // apb data

   // ------------------------------
   // register map
   // ------------------------------
   localparam logic [ADDR_W-1:0] CTRL_ADDR   = 8'h00;   // bit0 enable, bit1 symPhase
   localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h04;   // bit0 resultReady, bit1 overrun
   localparam logic [ADDR_W-1:0] COEFF_ADDR  = 8'h10;   // coeff 0..3 at 0x10..0x1c
   localparam logic [ADDR_W-1:0] RESULT_ADDR = 8'h20;   // mf0I, mf0Q, mf1I, mf1Q

   // complex input sample
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;
      logic signed [SAMPLE_W-1:0] q;
   } cplxSample_t;

   // complex coefficient, same layout as the apb word
   typedef struct packed {
      logic signed [COEFF_W-1:0] im;   // upper half
      logic signed [COEFF_W-1:0] re;   // lower half
   } cplxCoeff_t;

   typedef cplxSample_t [NUM_TAPS-1:0] tapWindow_t;   // element 0 oldest
   typedef cplxCoeff_t  [NUM_TAPS-1:0] coeffSet_t;

   // both filter outputs
   typedef struct packed {
      logic signed [RESULT_W-1:0] mf0I;
      logic signed [RESULT_W-1:0] mf0Q;
      logic signed [RESULT_W-1:0] mf1I;
      logic signed [RESULT_W-1:0] mf1Q;
   } mfResult_t;

endpackage

//--- dv/apbTasks.svh
// APB3 write/read tasks, register read check, address map and matched-filter reference model
`ifndef APB_TASKS_SVH
`define APB_TASKS_SVH

// ------------------------------
// APB3 master
// ------------------------------
// tasks start and end at DRV after a rising edge
task automatic apbWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
   psel    = 1'b1;   // setup phase
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = addr;
   pwdata  = data;
   @(posedge clk);
   #DRV;
   penable = 1'b1;   // access phase, write lands on next edge
   @(posedge clk);
   #DRV;
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apbRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = addr;
   @(posedge clk);
   #DRV;
   penable = 1'b1;
   @(negedge clk);
   data = prdata;   // mid-cycle, before the clear-on-read edge
   @(posedge clk);
   #DRV;
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic checkRead(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expData);
   logic [DATA_W-1:0] got;
   apbRead(addr, got);
   assert (got == expData)
      else stopWithError($sformatf("ERR prdata@%h exp %h got %h", addr, expData, got));
endtask

// mapped: ctrl, status, four coeffs, four results, word aligned
function automatic logic addrMapped(input logic [ADDR_W-1:0] addr);
   return (addr == 8'h00) || (addr == 8'h04) ||
          ((addr >= 8'h10) && (addr <= 8'h2c) && (addr[1:0] == 2'b00));
endfunction

// ------------------------------
// reference model
// ------------------------------
// mf0 = sum x*c, mf1 = sum x*conj(c), coeff k with window element k
function automatic mfResult_t calcResult(input tapWindow_t w, input coeffSet_t c);
   mfResult_t r;
   int        xi;
   int        xq;
   int        cr;
   int        ci;
   r = '0;
   for (int k = 0; k < NUM_TAPS; k++) begin
      xi = w[k].i;   // sign extended
      xq = w[k].q;
      cr = c[k].re;
      ci = c[k].im;
      r.mf0I = r.mf0I + xi * cr - xq * ci;
      r.mf0Q = r.mf0Q + xi * ci + xq * cr;
      r.mf1I = r.mf1I + xi * cr + xq * ci;
      r.mf1Q = r.mf1Q + xq * cr - xi * ci;
   end
   return r;
endfunction

`endif

//--- dv/multiHMfTb.sv
// testbench: clock, reset, APB and sample stimulus, reference tracking, watchdog, assertions
module multiHMfTb
   import mfPkg::*;
();

   localparam int PERIOD     = 40;
   localparam int DRV        = 2;    // input skew after the rising edge
   localparam int LATENCY    = 8;    // accept edge to the edge sampling resultValid high
   localparam int ARITH_SYMS = 30;
   localparam int PHASE_SYMS = 10;
   localparam int TOTAL_SYMS = ARITH_SYMS + PHASE_SYMS + 1;
   localparam int WATCH_CYC  = TOTAL_SYMS * 2 * 8 + 2000;   // 2 samples/symbol, worst gap 8

   logic              clk;
   logic              reset;
   logic [ADDR_W-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   cplxSample_t       sample;
   logic              sampleValid;
   mfResult_t         result;
   logic              resultValid;

   // reference state
   tapWindow_t         tbLine;       // last four accepted samples
   tapWindow_t         shiftedNow;
   logic               tbPhase;
   logic               tbEnable;     // shadow of CTRL
   logic               tbSymPhase;
   coeffSet_t          tbCoeffs;     // shadow of coeff regs
   logic               symNow;
   logic [LATENCY-1:0] expPipe;      // expected resultValid timing
   mfResult_t          expRes;
   int                 symCount;
   logic               expErr;
   logic [DATA_W-1:0]  rdData;

   multiHMf i_multiHMf (.*);

   initial clk = 1'b0;
   always #(PERIOD/2) clk = ~clk;

   task automatic stopWithError(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1);
   endtask

   `include "apbTasks.svh"

   // ------------------------------
   // reference tracking
   // ------------------------------
   assign shiftedNow = {sample, tbLine[NUM_TAPS-1:1]};   // newest at the top
   assign symNow     = tbEnable & sampleValid & (tbPhase == tbSymPhase);
   assign expErr     = psel & penable & ~addrMapped(paddr);

   always @(posedge clk) begin
      if (reset) begin
         tbLine   <= '0;
         tbPhase  <= 1'b0;
         expPipe  <= '0;
         expRes   <= '0;
         symCount <= 0;
      end else begin
         expPipe <= {expPipe[LATENCY-2:0], symNow};
         if (tbEnable && sampleValid) begin
            tbLine  <= shiftedNow;
            tbPhase <= ~tbPhase;
         end
         if (symNow) begin
            expRes   <= calcResult(shiftedNow, tbCoeffs);
            symCount <= symCount + 1;
         end
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   resultTiming: assert property (@(posedge clk) disable iff (reset)
      resultValid == expPipe[LATENCY-1])
      else stopWithError($sformatf("ERR resultValid exp %h got %h",
         $sampled(expPipe[LATENCY-1]), $sampled(resultValid)));

   resultValue: assert property (@(posedge clk) disable iff (reset)
      resultValid |-> result == expRes)
      else stopWithError($sformatf("ERR result exp %h got %h",
         $sampled(expRes), $sampled(result)));

   errorFlag: assert property (@(posedge clk) disable iff (reset) pslverr == expErr)
      else stopWithError($sformatf("ERR pslverr exp %h got %h",
         $sampled(expErr), $sampled(pslverr)));

   // no wait states on any access
   readyFlag: assert property (@(posedge clk) disable iff (reset) psel |-> pready)
      else stopWithError($sformatf("ERR pready exp %h got %h", 1'b1, $sampled(pready)));

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic sendSample();   // one pulse, next one 5..8 clocks later
      int unsigned gap;
      logic [31:0] rnd;
      gap = 5 + $urandom_range(3);
      rnd = $urandom;
      sample      = rnd[23:0];
      sampleValid = 1'b1;
      @(posedge clk);
      #DRV;
      sampleValid = 1'b0;
      repeat (gap - 1) @(posedge clk);
      #DRV;
   endtask

   task automatic runSymbols(input int n);
      int target;
      target = symCount + n;
      while (symCount < target) sendSample();
   endtask

   task automatic waitIdle();   // longer than one MAC pass
      repeat (12) @(posedge clk);
      #DRV;
   endtask

   task automatic writeCtrl(input logic en, input logic ph);
      apbWrite(CTRL_ADDR, {30'b0, ph, en});
      tbEnable   = en;
      tbSymPhase = ph;
      checkRead(CTRL_ADDR, {30'b0, ph, en});
   endtask

   task automatic writeCoeffs();
      for (int k = 0; k < NUM_TAPS; k++) begin
         tbCoeffs[k] = $urandom;
         apbWrite(COEFF_ADDR + ADDR_W'(4 * k), tbCoeffs[k]);
      end
      for (int k = 0; k < NUM_TAPS; k++) begin
         checkRead(COEFF_ADDR + ADDR_W'(4 * k), tbCoeffs[k]);
      end
   endtask

   task automatic checkResultRegs();
      checkRead(RESULT_ADDR,         expRes.mf0I);
      checkRead(RESULT_ADDR + 8'h04, expRes.mf0Q);
      checkRead(RESULT_ADDR + 8'h08, expRes.mf1I);
      checkRead(RESULT_ADDR + 8'h0c, expRes.mf1Q);
   endtask

   // watchdog
   initial begin
      #(WATCH_CYC * PERIOD);
      stopWithError("timeout: the test sequence did not complete in time");
   end

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      void'($urandom(24735));
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      sample      = '0;
      sampleValid = 1'b0;
      tbEnable    = 1'b0;
      tbSymPhase  = 1'b0;
      tbCoeffs    = '0;
      repeat (16) @(posedge clk);
      #DRV;
      reset = 1'b0;

      // disabled, samples dropped and every register zero
      repeat (6) sendSample();
      waitIdle();
      checkRead(CTRL_ADDR, '0);
      checkRead(STATUS_ADDR, '0);
      for (int a = COEFF_ADDR; a <= RESULT_ADDR + 12; a += 4) begin
         checkRead(ADDR_W'(a), '0);
      end

      // arithmetic, no status reads so overrun builds up
      writeCoeffs();
      writeCtrl(1'b1, 1'b0);
      runSymbols(ARITH_SYMS);
      waitIdle();
      checkRead(STATUS_ADDR, 32'h3);
      checkRead(STATUS_ADDR, 32'h0);   // cleared by the read
      checkResultRegs();

      // other sample of each pair
      writeCoeffs();
      writeCtrl(1'b1, 1'b1);
      runSymbols(PHASE_SYMS);
      waitIdle();
      checkRead(STATUS_ADDR, 32'h3);
      checkRead(STATUS_ADDR, 32'h0);
      runSymbols(1);   // single result, ready without overrun
      waitIdle();
      checkRead(STATUS_ADDR, 32'h1);
      checkRead(STATUS_ADDR, 32'h0);
      checkResultRegs();

      // unmapped and misaligned
      apbRead(8'h08, rdData);
      apbRead(8'h12, rdData);
      apbWrite(8'h30, 32'hdeadbeef);
      apbWrite(8'h44, 32'h12345678);
      waitIdle();

      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- mfilt/complexMac.sv
// pipelined multiply-accumulate of one real product stream
module complexMac
   import mfPkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic signed [COEFF_W-1:0]  a,        // coefficient part
   input  logic signed [SAMPLE_W-1:0] b,        // sample part
   input  logic                       first,    // first product of a sum
   input  logic                       last,     // last product of a sum
   output logic signed [RESULT_W-1:0] acc,
   output logic                       accDone   // acc holds a finished sum
);

   localparam int PROD_W = COEFF_W + SAMPLE_W;

   logic signed [PROD_W-1:0]   prod;      // registered product
   logic signed [RESULT_W-1:0] prodExt;
   logic                       firstD;    // flags aligned with prod
   logic                       lastD;

   // sign extend to accumulator width
   assign prodExt = {{(RESULT_W-PROD_W){prod[PROD_W-1]}}, prod};

   // ------------------------------
   // datapath
   // ------------------------------
   always_ff @(posedge clk) begin
      prod <= a * b;   // stage 1
      if (firstD) begin
         acc <= prodExt;   // start a new sum
      end else begin
         acc <= acc + prodExt;
      end
   end

   // ------------------------------
   // flag pipeline
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         firstD  <= 1'b0;
         lastD   <= 1'b0;
         accDone <= 1'b0;
      end else begin
         firstD  <= first;
         lastD   <= last;
         accDone <= lastD;   // last product is in acc now
      end
   end

endmodule

//--- mfilt/mfilt.sv
// tap sequencer, four MAC lanes and the mf0/mf1 combine stage
module mfilt
   import mfPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       symEn,         // start of a MAC pass
   input  tapWindow_t window,
   input  coeffSet_t  coeffs,
   output mfResult_t  result,
   output logic       resultValid    // 7 cycles after symEn
);

   localparam int TAP_W = $clog2(NUM_TAPS);

   logic                       busy;      // pass in progress
   logic [TAP_W-1:0]           tapCnt;
   logic                       first;
   logic                       last;
   cplxCoeff_t                 curCoeff;
   cplxSample_t                curSample;
   logic signed [RESULT_W-1:0] accA;      // sum re*i
   logic signed [RESULT_W-1:0] accB;      // sum im*q
   logic signed [RESULT_W-1:0] accC;      // sum im*i
   logic signed [RESULT_W-1:0] accD;      // sum re*q
   logic [3:0]                 done;
   logic                       allDone;

   // ------------------------------
   // tap sequencer
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         busy   <= 1'b0;
         tapCnt <= '0;
      end else if (symEn) begin
         busy   <= 1'b1;
         tapCnt <= '0;
      end else if (busy) begin
         if (tapCnt == TAP_W'(NUM_TAPS-1)) begin
            busy <= 1'b0;   // four taps issued
         end
         tapCnt <= tapCnt + 1'b1;
      end
   end

   assign first = busy & (tapCnt == '0);
   assign last  = busy & (tapCnt == TAP_W'(NUM_TAPS-1));

   // coefficient k pairs with window element k, zeros between passes
   assign curCoeff  = busy ? coeffs[tapCnt] : '0;
   assign curSample = busy ? window[tapCnt] : '0;

   // ------------------------------
   // MAC lanes
   // ------------------------------
   complexMac i_macA (.clk, .reset, .a(curCoeff.re), .b(curSample.i),
                      .first, .last, .acc(accA), .accDone(done[0]));
   complexMac i_macB (.clk, .reset, .a(curCoeff.im), .b(curSample.q),
                      .first, .last, .acc(accB), .accDone(done[1]));
   complexMac i_macC (.clk, .reset, .a(curCoeff.im), .b(curSample.i),
                      .first, .last, .acc(accC), .accDone(done[2]));
   complexMac i_macD (.clk, .reset, .a(curCoeff.re), .b(curSample.q),
                      .first, .last, .acc(accD), .accDone(done[3]));

   assign allDone = &done;   // lanes run in lockstep

   // ------------------------------
   // combine into mf0 / mf1
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         result      <= '0;
         resultValid <= 1'b0;
      end else begin
         resultValid <= allDone;
         if (allDone) begin
            result.mf0I <= accA - accB;   // x * c
            result.mf0Q <= accC + accD;
            result.mf1I <= accA + accB;   // x * conj(c)
            result.mf1Q <= accD - accC;
         end
      end
   end

endmodule

//--- multiHMf.f
+incdir+dv
common/mfPkg.sv
src/sampleDelay.sv
mfilt/complexMac.sv
mfilt/mfilt.sv
src/mfApbRegs.sv
src/multiHMf.sv
dv/multiHMfTb.sv

//--- src/mfApbRegs.sv
// APB3 slave: control, coefficient, status and result registers
module mfApbRegs
   import mfPkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic [ADDR_W-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   input  mfResult_t         result,
   input  logic              resultValid,
   output logic              enable,
   output logic              symPhase,
   output coeffSet_t         coeffs
);

   mfResult_t resultReg;     // latest result
   logic      resultReady;
   logic      overrun;       // a result arrived before STATUS was read
   logic      isCtrl;
   logic      isStatus;
   logic      isCoeff;
   logic      isResult;
   logic      mapped;
   logic      access;        // access phase
   logic      wrEn;
   logic      statusRd;

   // ------------------------------
   // address decode
   // ------------------------------
   assign isCtrl   = (paddr == CTRL_ADDR);
   assign isStatus = (paddr == STATUS_ADDR);
   assign isCoeff  = (paddr[7:4] == COEFF_ADDR[7:4]) && (paddr[1:0] == 2'b00);
   assign isResult = (paddr[7:4] == RESULT_ADDR[7:4]) && (paddr[1:0] == 2'b00);
   assign mapped   = isCtrl | isStatus | isCoeff | isResult;

   assign access   = psel & penable;
   assign wrEn     = access & pwrite & mapped;
   assign statusRd = access & ~pwrite & isStatus;   // clear-on-read trigger

   assign pready  = 1'b1;                 // no wait states
   assign pslverr = access & ~mapped;

   // ------------------------------
   // config registers
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         enable   <= 1'b0;
         symPhase <= 1'b0;
         coeffs   <= '0;
      end else if (wrEn) begin
         if (isCtrl) begin
            enable   <= pwdata[0];
            symPhase <= pwdata[1];
         end
         if (isCoeff) begin
            coeffs[paddr[3:2]] <= pwdata;   // im:re packed like the struct
         end
      end
   end

   // ------------------------------
   // status and result capture
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         resultReg   <= '0;
         resultReady <= 1'b0;
         overrun     <= 1'b0;
      end else begin
         if (resultValid) begin
            resultReg   <= result;
            resultReady <= 1'b1;   // a new result beats the clear
            overrun     <= resultReady | (overrun & ~statusRd);
         end else if (statusRd) begin
            resultReady <= 1'b0;
            overrun     <= 1'b0;
         end
      end
   end

   // ------------------------------
   // read mux
   // ------------------------------
   always_comb begin
      prdata = '0;
      if (isCtrl) begin
         prdata = DATA_W'({symPhase, enable});
      end else if (isStatus) begin
         prdata = DATA_W'({overrun, resultReady});
      end else if (isCoeff) begin
         prdata = coeffs[paddr[3:2]];
      end else if (isResult) begin
         case (paddr[3:2])
            2'd0:    prdata = resultReg.mf0I;
            2'd1:    prdata = resultReg.mf0Q;
            2'd2:    prdata = resultReg.mf1I;
            default: prdata = resultReg.mf1Q;
         endcase
      end
   end

endmodule

//--- src/multiHMf.sv
// top level: input side, matched filter and register block
module multiHMf
   import mfPkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // apb3 slave
   input  logic [ADDR_W-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // sample stream, 2 samples per symbol
   input  cplxSample_t       sample,
   input  logic              sampleValid,
   // result strobe
   output mfResult_t         result,
   output logic              resultValid
);

   logic       enable;
   logic       symPhase;
   coeffSet_t  coeffs;
   tapWindow_t window;
   logic       symEn;

   // ------------------------------
   // blocks
   // ------------------------------
   sampleDelay i_sampleDelay (
      .clk, .reset, .enable, .symPhase,
      .sample, .sampleValid,
      .window, .symEn
   );

   mfilt i_mfilt (
      .clk, .reset, .symEn, .window, .coeffs,
      .result, .resultValid
   );

   mfApbRegs i_mfApbRegs (
      .clk, .reset,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .result, .resultValid,
      .enable, .symPhase, .coeffs
   );

endmodule

//--- src/sampleDelay.sv
// input side: sample shift line, symbol phase select, frozen tap window
module sampleDelay
   import mfPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        enable,      // samples ignored while low
   input  logic        symPhase,    // which sample of each pair is the symbol sample
   input  cplxSample_t sample,
   input  logic        sampleValid,
   output tapWindow_t  window,      // stable taps for one symbol
   output logic        symEn        // one cycle after the symbol sample
);

   tapWindow_t line;      // running line at the 2x rate
   tapWindow_t shifted;   // line with the new sample pushed in
   logic       phase;     // toggles per accepted sample
   logic       accept;
   logic       symSample;

   // ------------------------------
   // accept / symbol decode
   // ------------------------------
   assign accept    = enable & sampleValid;
   assign symSample = accept & (phase == symPhase);   // phase before the toggle

   // newest sample enters at the top, oldest drops off element 0
   assign shifted = {sample, line[NUM_TAPS-1:1]};

   // ------------------------------
   // shift line and window latch
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         line   <= '0;
         phase  <= 1'b0;
         window <= '0;
         symEn  <= 1'b0;
      end else begin
         symEn <= symSample;   // pulses alongside the new window
         if (accept) begin
            line  <= shifted;
            phase <= ~phase;
         end
         // freeze a copy so the MAC pass sees fixed taps
         if (symSample) begin
            window <= shifted;
         end
      end
   end

endmodule
